// File: Bender.yml
package:
  name: issue_stage

export_include_dirs:
  - .

sources:
  - isa_pkg.sv
  - sb_pkg.sv
  - issue_if.sv
  - regfile.sv
  - scoreboard.sv
  - issue_read_operands.sv
  - issue_stage.sv
  - target: test
    files:
      - issue_stage_asserts.sv
      - tb_issue_stage.sv

// File: isa_pkg.sv
// instruction-level types
// functional units, operators and the decoded instruction
`include "issue_config.svh"

package isa_pkg;

    // architectural register number
    typedef logic [$clog2(`NR_REGS)-1:0] reg_addr_t;

    // target unit, NONE never waits on a ready
    typedef enum logic [1:0] {
        NONE = 2'd0,
        ALU  = 2'd1,
        LSU  = 2'd2,
        MULT = 2'd3
    } fu_t;

    // operator code handed to the unit
    typedef enum logic [3:0] {
        ADD = 4'd0,
        SUB = 4'd1,
        AND = 4'd2,
        OR  = 4'd3,
        XOR = 4'd4,
        LD  = 4'd5,
        SD  = 4'd6,
        MUL = 4'd7
    } fu_op_t;

    // decoded instruction as delivered by decode
    typedef struct packed {
        fu_t              fu;
        fu_op_t           op;
        reg_addr_t        rd;
        reg_addr_t        rs1;
        reg_addr_t        rs2;
        logic [`XLEN-1:0] imm;
        logic             use_imm;
        logic [`XLEN-1:0] pc;
        logic             use_pc;
    } instr_t;

endpackage

// File: issue_config.svh
// issue stage configuration
// widths and sizes shared by the packages and the RTL
`ifndef ISSUE_CONFIG_SVH
`define ISSUE_CONFIG_SVH

// register and operand width
`define XLEN 64
// architectural registers
`define NR_REGS 32
// scoreboard entries, a power of two
`define SB_DEPTH 8
// index into the scoreboard
`define TRANS_ID_BITS 3

`endif

// File: issue_if.sv
// scoreboard to issue connection
// oldest unissued entry, operand lookups and the clobber table
`timescale 1ns/1ps
`include "issue_config.svh"

interface issue_if import isa_pkg::*, sb_pkg::*; ();

    // entry offered for issue
    sb_entry_t        issue_entry;
    logic             issue_valid;
    logic             issue_ack;

    // forwarding lookups, combinational
    reg_addr_t        rs1_addr;
    logic [`XLEN-1:0] rs1_data;
    logic             rs1_valid;
    reg_addr_t        rs2_addr;
    logic [`XLEN-1:0] rs2_data;
    logic             rs2_valid;

    // pending writers per register
    clobber_t         clobber;

    modport sb (
        output issue_entry, issue_valid,
        output rs1_data, rs1_valid, rs2_data, rs2_valid,
        output clobber,
        input  issue_ack, rs1_addr, rs2_addr
    );

    modport iss (
        input  issue_entry, issue_valid,
        input  rs1_data, rs1_valid, rs2_data, rs2_valid,
        input  clobber,
        output issue_ack, rs1_addr, rs2_addr
    );

endinterface

// File: issue_read_operands.sv
// issue and operand read
// decides when the oldest entry may go, picks its operands from the
// register file, forwarding, pc or immediate, and registers them for the units
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_read_operands import isa_pkg::*, sb_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    // from the scoreboard
    issue_if.iss             issue_port,
    // register file reads
    output reg_addr_t        rf_raddr_a_o,
    output reg_addr_t        rf_raddr_b_o,
    input  logic [`XLEN-1:0] rf_rdata_a_i,
    input  logic [`XLEN-1:0] rf_rdata_b_i,
    // unit readiness levels
    input  logic             alu_ready_i,
    input  logic             lsu_ready_i,
    input  logic             mult_ready_i,
    // toward the units
    output fu_op_t           operator_o,
    output logic [`XLEN-1:0] operand_a_o,
    output logic [`XLEN-1:0] operand_b_o,
    output trans_id_t        trans_id_o,
    output logic             alu_valid_o,
    output logic             lsu_valid_o,
    output logic             mult_valid_o
);

    instr_t           instr;
    logic             fu_ready;
    logic             rd_free;
    logic             rs1_busy;
    logic             rs2_busy;
    logic [`XLEN-1:0] operand_a_d;
    logic [`XLEN-1:0] operand_b_d;
    logic             alu_valid_d;
    logic             lsu_valid_d;
    logic             mult_valid_d;

    assign instr = issue_port.issue_entry.instr;

    // sources go to both the register file and the scoreboard lookup
    assign rf_raddr_a_o        = instr.rs1;
    assign rf_raddr_b_o        = instr.rs2;
    assign issue_port.rs1_addr = instr.rs1;
    assign issue_port.rs2_addr = instr.rs2;

    // ----------------------------------------
    // issue decision
    // ----------------------------------------
    always_comb begin : unit_ready
        unique case (instr.fu)
            ALU:     fu_ready = alu_ready_i;
            LSU:     fu_ready = lsu_ready_i;
            MULT:    fu_ready = mult_ready_i;
            default: fu_ready = 1'b1;
        endcase
    end

    // WAW hazard, an older writer of rd still in flight
    assign rd_free  = (issue_port.clobber[instr.rd] == NONE);
    // source pending and its result not captured yet
    assign rs1_busy = (issue_port.clobber[instr.rs1] != NONE) && !issue_port.rs1_valid;
    assign rs2_busy = (issue_port.clobber[instr.rs2] != NONE) && !issue_port.rs2_valid;

    assign issue_port.issue_ack = issue_port.issue_valid && fu_ready && rd_free
                                  && !rs1_busy && !rs2_busy;

    // ----------------------------------------
    // operand select
    // ----------------------------------------
    always_comb begin : operand_mux
        // regfile by default
        operand_a_d = rf_rdata_a_i;
        operand_b_d = rf_rdata_b_i;
        // pending producer already wrote back
        if (issue_port.clobber[instr.rs1] != NONE) begin
            operand_a_d = issue_port.rs1_data;
        end
        if (issue_port.clobber[instr.rs2] != NONE) begin
            operand_b_d = issue_port.rs2_data;
        end
        // pc and immediate override
        if (instr.use_pc) begin
            operand_a_d = instr.pc;
        end
        if (instr.use_imm) begin
            operand_b_d = instr.imm;
        end
    end

    // one-hot unit strobe, only on an acknowledged cycle
    assign alu_valid_d  = issue_port.issue_ack && (instr.fu == ALU);
    assign lsu_valid_d  = issue_port.issue_ack && (instr.fu == LSU);
    assign mult_valid_d = issue_port.issue_ack && (instr.fu == MULT);

    // ----------------------------------------
    // output register
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : out_ctrl
        if (!rst_ni) begin
            alu_valid_o  <= 1'b0;
            lsu_valid_o  <= 1'b0;
            mult_valid_o <= 1'b0;
            operator_o   <= ADD;
        end else if (flush_i) begin
            alu_valid_o  <= 1'b0;
            lsu_valid_o  <= 1'b0;
            mult_valid_o <= 1'b0;
            operator_o   <= ADD;
        end else begin
            // valids last a single cycle
            alu_valid_o  <= alu_valid_d;
            lsu_valid_o  <= lsu_valid_d;
            mult_valid_o <= mult_valid_d;
            if (issue_port.issue_ack) begin
                operator_o <= instr.op;
            end
        end
    end

    // operands and id only move with an issue
    always_ff @(posedge clk_i) begin : out_data
        if (issue_port.issue_ack) begin
            operand_a_o <= operand_a_d;
            operand_b_o <= operand_b_d;
            trans_id_o  <= issue_port.issue_entry.trans_id;
        end
    end

endmodule

// File: issue_stage.f
+incdir+.
isa_pkg.sv
sb_pkg.sv
issue_if.sv
regfile.sv
scoreboard.sv
issue_read_operands.sv
issue_stage.sv
issue_stage_asserts.sv
tb_issue_stage.sv

// File: issue_stage.sv
// issue stage top
// scoreboard, issue block and register file behind plain ports
`timescale 1ns/1ps
`include "issue_config.svh"

module issue_stage import isa_pkg::*, sb_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    // decoded instruction
    input  logic             dec_valid_i,
    input  fu_t              dec_fu_i,
    input  fu_op_t           dec_op_i,
    input  reg_addr_t        dec_rd_i,
    input  reg_addr_t        dec_rs1_i,
    input  reg_addr_t        dec_rs2_i,
    input  logic [`XLEN-1:0] dec_imm_i,
    input  logic             dec_use_imm_i,
    input  logic [`XLEN-1:0] dec_pc_i,
    input  logic             dec_use_pc_i,
    output logic             dec_full_o,
    // writeback
    input  logic             wb_valid_i,
    input  trans_id_t        wb_trans_id_i,
    input  logic [`XLEN-1:0] wb_data_i,
    // units
    input  logic             alu_ready_i,
    input  logic             lsu_ready_i,
    input  logic             mult_ready_i,
    output fu_op_t           operator_o,
    output logic [`XLEN-1:0] operand_a_o,
    output logic [`XLEN-1:0] operand_b_o,
    output trans_id_t        trans_id_o,
    output logic             alu_valid_o,
    output logic             lsu_valid_o,
    output logic             mult_valid_o
);

    instr_t           dec_instr;
    // commit path into the register file
    logic             commit_we;
    reg_addr_t        commit_addr;
    logic [`XLEN-1:0] commit_data;
    // register file reads
    reg_addr_t        rf_raddr_a;
    reg_addr_t        rf_raddr_b;
    logic [`XLEN-1:0] rf_rdata_a;
    logic [`XLEN-1:0] rf_rdata_b;

    issue_if issue_bus ();

    // gather decode fields
    assign dec_instr = '{
        fu:      dec_fu_i,
        op:      dec_op_i,
        rd:      dec_rd_i,
        rs1:     dec_rs1_i,
        rs2:     dec_rs2_i,
        imm:     dec_imm_i,
        use_imm: dec_use_imm_i,
        pc:      dec_pc_i,
        use_pc:  dec_use_pc_i
    };

    scoreboard u_scoreboard (
        .clk_i         (clk_i),
        .rst_ni        (rst_ni),
        .flush_i       (flush_i),
        .dec_valid_i   (dec_valid_i),
        .dec_instr_i   (dec_instr),
        .dec_full_o    (dec_full_o),
        .wb_valid_i    (wb_valid_i),
        .wb_trans_id_i (wb_trans_id_i),
        .wb_data_i     (wb_data_i),
        .issue_port    (issue_bus.sb),
        .commit_we_o   (commit_we),
        .commit_addr_o (commit_addr),
        .commit_data_o (commit_data)
    );

    issue_read_operands u_issue (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .flush_i      (flush_i),
        .issue_port   (issue_bus.iss),
        .rf_raddr_a_o (rf_raddr_a),
        .rf_raddr_b_o (rf_raddr_b),
        .rf_rdata_a_i (rf_rdata_a),
        .rf_rdata_b_i (rf_rdata_b),
        .alu_ready_i  (alu_ready_i),
        .lsu_ready_i  (lsu_ready_i),
        .mult_ready_i (mult_ready_i),
        .operator_o   (operator_o),
        .operand_a_o  (operand_a_o),
        .operand_b_o  (operand_b_o),
        .trans_id_o   (trans_id_o),
        .alu_valid_o  (alu_valid_o),
        .lsu_valid_o  (lsu_valid_o),
        .mult_valid_o (mult_valid_o)
    );

    regfile u_regfile (
        .clk_i     (clk_i),
        .rst_ni    (rst_ni),
        .raddr_a_i (rf_raddr_a),
        .rdata_a_o (rf_rdata_a),
        .raddr_b_i (rf_raddr_b),
        .rdata_b_o (rf_rdata_b),
        .waddr_i   (commit_addr),
        .wdata_i   (commit_data),
        .we_i      (commit_we)
    );

endmodule

// File: issue_stage_asserts.sv
// issue stage protocol checks
// unit strobes, readiness, flush and full behaviour seen at the top ports
`timescale 1ns/1ps

module issue_stage_asserts import isa_pkg::*, sb_pkg::*; (
    input logic      clk_i,
    input logic      rst_ni,
    input logic      flush_i,
    input logic      dec_full_o,
    input logic      alu_ready_i,
    input logic      lsu_ready_i,
    input logic      mult_ready_i,
    input logic      alu_valid_o,
    input logic      lsu_valid_o,
    input logic      mult_valid_o,
    input fu_op_t    operator_o,
    input trans_id_t trans_id_o,
    // head retiring into the register file
    input logic      commit_we_i
);

    // read back by the testbench for its closing report
    int unsigned fail_cnt = 0;
    logic        any_valid;

    assign any_valid = alu_valid_o | lsu_valid_o | mult_valid_o;

    // ----------------------------------------
    // unit strobes
    // ----------------------------------------
    // at most one unit per cycle
    valid_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0({alu_valid_o, lsu_valid_o, mult_valid_o}))
        else begin
            fail_cnt++;
            $error("more than one unit valid in the same cycle");
        end

    // issue edge saw the unit ready
    alu_ready_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        alu_valid_o |-> $past(alu_ready_i))
        else begin
            fail_cnt++;
            $error("alu valid after an issue while alu was not ready");
        end

    lsu_ready_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        lsu_valid_o |-> $past(lsu_ready_i))
        else begin
            fail_cnt++;
            $error("lsu valid after an issue while lsu was not ready");
        end

    mult_ready_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mult_valid_o |-> $past(mult_ready_i))
        else begin
            fail_cnt++;
            $error("mult valid after an issue while mult was not ready");
        end

    // back to back strobes carry different entries
    no_repeat: assert property (@(posedge clk_i) disable iff (!rst_ni)
        any_valid |=> !any_valid || (trans_id_o != $past(trans_id_o)))
        else begin
            fail_cnt++;
            $error("same transaction id strobed twice in a row");
        end

    // ----------------------------------------
    // flush and full
    // ----------------------------------------
    flush_clears: assert property (@(posedge clk_i) disable iff (!rst_ni)
        flush_i |=> !any_valid && !dec_full_o && (operator_o == ADD))
        else begin
            fail_cnt++;
            $error("outputs not cleared one cycle after flush");
        end

    // only a commit or a flush frees a slot
    full_until_commit: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $fell(dec_full_o) |-> $past(commit_we_i) || $past(flush_i))
        else begin
            fail_cnt++;
            $error("full dropped without a commit or flush");
        end

endmodule

bind issue_stage issue_stage_asserts u_asserts (
    .*,
    .commit_we_i (commit_we)
);

// File: regfile.sv
// integer register file
// two combinational read ports, one write port, x0 hardwired to zero
`timescale 1ns/1ps
`include "issue_config.svh"

module regfile import isa_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    // read ports
    input  reg_addr_t        raddr_a_i,
    output logic [`XLEN-1:0] rdata_a_o,
    input  reg_addr_t        raddr_b_i,
    output logic [`XLEN-1:0] rdata_b_o,
    // write port, driven by commit
    input  reg_addr_t        waddr_i,
    input  logic [`XLEN-1:0] wdata_i,
    input  logic             we_i
);

    // x1 .. x31 only
    logic [`XLEN-1:0] regs_q [1:`NR_REGS-1];

    // x0 never stored
    assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs_q[raddr_a_i];
    assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs_q[raddr_b_i];

    always_ff @(posedge clk_i or negedge rst_ni) begin : reg_write
        if (!rst_ni) begin
            for (int i = 1; i < `NR_REGS; i++) begin
                regs_q[i] <= '0;
            end
        end else if (we_i && (waddr_i != '0)) begin
            regs_q[waddr_i] <= wdata_i;
        end
    end

endmodule

// File: sb_pkg.sv
// scoreboard-level types
// entry layout and the per-register clobber table
`include "issue_config.svh"

package sb_pkg;

    import isa_pkg::*;

    // slot index, doubles as the transaction id seen by the units
    typedef logic [`TRANS_ID_BITS-1:0] trans_id_t;

    // one scoreboard slot
    typedef struct packed {
        instr_t           instr;
        trans_id_t        trans_id;
        // handed to a unit already
        logic             issued;
        // written back, waiting for commit
        logic [`XLEN-1:0] result;
        logic             result_valid;
    } sb_entry_t;

    // which unit will write each register, NONE if no writer in flight
    typedef fu_t [`NR_REGS-1:0] clobber_t;

endpackage

// File: scoreboard.sv
// scoreboard
// circular buffer of decoded instructions between decode and commit,
// tracks pending writers, captures results out of order, commits in order
`timescale 1ns/1ps
`include "issue_config.svh"

module scoreboard import isa_pkg::*, sb_pkg::*; (
    input  logic             clk_i,
    input  logic             rst_ni,
    input  logic             flush_i,
    // decode side
    input  logic             dec_valid_i,
    input  instr_t           dec_instr_i,
    output logic             dec_full_o,
    // writeback strobe from the units
    input  logic             wb_valid_i,
    input  trans_id_t        wb_trans_id_i,
    input  logic [`XLEN-1:0] wb_data_i,
    // toward issue
    issue_if.sb              issue_port,
    // commit into the register file
    output logic             commit_we_o,
    output reg_addr_t        commit_addr_o,
    output logic [`XLEN-1:0] commit_data_o
);

    // slot storage, qualified by valid_q
    sb_entry_t            mem_q [`SB_DEPTH];
    logic [`SB_DEPTH-1:0] valid_q;
    // oldest, next to issue, next free
    trans_id_t            head_q;
    trans_id_t            issue_q;
    trans_id_t            tail_q;

    logic                 accept;
    logic                 issue_fire;
    logic                 commit;

    // ----------------------------------------
    // pointers and handshakes
    // ----------------------------------------
    // free slot at tail unless every entry is taken
    assign dec_full_o = valid_q[tail_q];
    assign accept     = dec_valid_i && !dec_full_o && !flush_i;

    // entries issue in order, so the slot at issue_q is the oldest unissued
    assign issue_port.issue_entry = mem_q[issue_q];
    assign issue_port.issue_valid = valid_q[issue_q] && !mem_q[issue_q].issued;
    assign issue_fire             = issue_port.issue_valid && issue_port.issue_ack;

    // head retires once issued and written back
    assign commit        = valid_q[head_q] && mem_q[head_q].issued
                           && mem_q[head_q].result_valid;
    assign commit_we_o   = commit;
    assign commit_addr_o = mem_q[head_q].instr.rd;
    assign commit_data_o = mem_q[head_q].result;

    // ----------------------------------------
    // clobber table and forwarding lookup
    // ----------------------------------------
    // walk oldest to youngest so the youngest writer wins
    always_comb begin : clobber_lookup
        trans_id_t idx;
        for (int r = 0; r < `NR_REGS; r++) begin
            issue_port.clobber[r] = NONE;
        end
        issue_port.rs1_data  = '0;
        issue_port.rs1_valid = 1'b0;
        issue_port.rs2_data  = '0;
        issue_port.rs2_valid = 1'b0;
        for (int i = 0; i < `SB_DEPTH; i++) begin
            idx = head_q + trans_id_t'(i);
            // only issued writers are in flight, x0 never counts
            if (valid_q[idx] && mem_q[idx].issued && (mem_q[idx].instr.rd != '0)) begin
                issue_port.clobber[mem_q[idx].instr.rd] = mem_q[idx].instr.fu;
                if (mem_q[idx].instr.rd == issue_port.rs1_addr) begin
                    issue_port.rs1_data  = mem_q[idx].result;
                    issue_port.rs1_valid = mem_q[idx].result_valid;
                end
                if (mem_q[idx].instr.rd == issue_port.rs2_addr) begin
                    issue_port.rs2_data  = mem_q[idx].result;
                    issue_port.rs2_valid = mem_q[idx].result_valid;
                end
            end
        end
    end

    // ----------------------------------------
    // state
    // ----------------------------------------
    always_ff @(posedge clk_i or negedge rst_ni) begin : ctrl_regs
        if (!rst_ni) begin
            valid_q <= '0;
            head_q  <= '0;
            issue_q <= '0;
            tail_q  <= '0;
        end else if (flush_i) begin
            // drop everything in flight
            valid_q <= '0;
            head_q  <= '0;
            issue_q <= '0;
            tail_q  <= '0;
        end else begin
            if (accept) begin
                valid_q[tail_q] <= 1'b1;
                tail_q          <= tail_q + 1'b1;
            end
            if (issue_fire) begin
                issue_q <= issue_q + 1'b1;
            end
            // head slot differs from tail slot, no conflict with accept
            if (commit) begin
                valid_q[head_q] <= 1'b0;
                head_q          <= head_q + 1'b1;
            end
        end
    end

    // slot contents, meaningful only while valid_q is set
    always_ff @(posedge clk_i) begin : entry_write
        if (accept) begin
            mem_q[tail_q].instr        <= dec_instr_i;
            mem_q[tail_q].trans_id     <= tail_q;
            mem_q[tail_q].issued       <= 1'b0;
            mem_q[tail_q].result_valid <= 1'b0;
        end
        if (issue_fire) begin
            mem_q[issue_q].issued <= 1'b1;
        end
        // results arrive in any order
        if (wb_valid_i) begin
            mem_q[wb_trans_id_i].result       <= wb_data_i;
            mem_q[wb_trans_id_i].result_valid <= 1'b1;
        end
    end

endmodule

// File: tb_issue_stage.sv
// testbench for the issue stage
// plays decode and the three execution units, keeps a program-order
// register model and checks every issued operand against it
`timescale 1ns/1ps
`include "issue_config.svh"

module tb_issue_stage import isa_pkg::*, sb_pkg::*; ();

    localparam int N_RAND  = 60;
    localparam int N_FLUSH = `SB_DEPTH;
    localparam int N_TAIL  = 12;
    localparam int N_INSTR = N_RAND + `SB_DEPTH + N_FLUSH + N_TAIL;
    localparam int CLK_NS  = 4;

    // expected issue, built at acceptance in program order
    typedef struct packed {
        fu_t              fu;
        fu_op_t           op;
        reg_addr_t        rd;
        logic [`XLEN-1:0] a;
        logic [`XLEN-1:0] b;
        trans_id_t        id;
    } exp_t;

    // writeback waiting in a unit model
    typedef struct packed {
        fu_t              fu;
        reg_addr_t        rd;
        trans_id_t        id;
        logic [`XLEN-1:0] data;
        int unsigned      due;
    } wb_t;

    logic             clk_i;
    logic             rst_ni;
    logic             flush_i;
    logic             dec_valid_i;
    fu_t              dec_fu_i;
    fu_op_t           dec_op_i;
    reg_addr_t        dec_rd_i;
    reg_addr_t        dec_rs1_i;
    reg_addr_t        dec_rs2_i;
    logic [`XLEN-1:0] dec_imm_i;
    logic             dec_use_imm_i;
    logic [`XLEN-1:0] dec_pc_i;
    logic             dec_use_pc_i;
    logic             dec_full_o;
    logic             wb_valid_i;
    trans_id_t        wb_trans_id_i;
    logic [`XLEN-1:0] wb_data_i;
    logic             alu_ready_i;
    logic             lsu_ready_i;
    logic             mult_ready_i;
    fu_op_t           operator_o;
    logic [`XLEN-1:0] operand_a_o;
    logic [`XLEN-1:0] operand_b_o;
    trans_id_t        trans_id_o;
    logic             alu_valid_o;
    logic             lsu_valid_o;
    logic             mult_valid_o;

    // program-order register model and a copy taken before a flush
    logic [`XLEN-1:0] ref_rf [`NR_REGS];
    logic [`XLEN-1:0] saved_rf [`NR_REGS];
    exp_t             exp_q [$];
    wb_t              wb_q [$];
    trans_id_t        next_id;
    int unsigned      cycle = 0;
    int unsigned      val_errs;
    int unsigned      asrt_errs;
    bit               hold_ready;
    bit               force_ready;

    issue_stage dut0 (.*);

    initial begin : clock_gen
        clk_i = 1'b0;
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) cycle++;

    // ----------------------------------------
    // helpers
    // ----------------------------------------
    // what the unit models compute
    function automatic logic [`XLEN-1:0] unit_result(fu_op_t op, logic [`XLEN-1:0] a,
                                                     logic [`XLEN-1:0] b);
        case (op)
            SUB:     return a - b;
            AND:     return a & b;
            OR:      return a | b;
            XOR:     return a ^ b;
            // stand-in for a memory read
            LD:      return {a[31:0], b[31:0]} ^ 64'h0123_4567_89ab_cdef;
            SD:      return b;
            MUL:     return a * b;
            default: return a + b;
        endcase
    endfunction

    task automatic report_error(string msg);
        val_errs++;
        $display("ERROR @%0t: %s", $time, msg);
    endtask

    task automatic expect_equal(string what, logic [`XLEN-1:0] got, logic [`XLEN-1:0] exp);
        if (got !== exp) begin
            report_error($sformatf("%s got %h, expected %h", what, got, exp));
        end
    endtask

    // n cycles, ends 1 ns after an edge
    task automatic idle(int n);
        repeat (n) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // ready levels change at the next edge
    task automatic set_hold(bit h);
        @(negedge clk_i);
        hold_ready = h;
        @(posedge clk_i);
        #1;
    endtask

    // offer one instruction until accepted, then update the model
    task automatic send(fu_t fu, fu_op_t op, reg_addr_t rd, reg_addr_t rs1, reg_addr_t rs2,
                        logic use_imm, logic use_pc);
        exp_t e;
        bit   taken;
        dec_valid_i   = 1'b1;
        dec_fu_i      = fu;
        dec_op_i      = op;
        dec_rd_i      = rd;
        dec_rs1_i     = rs1;
        dec_rs2_i     = rs2;
        dec_imm_i     = {$urandom, $urandom};
        dec_use_imm_i = use_imm;
        dec_pc_i      = {$urandom, $urandom};
        dec_use_pc_i  = use_pc;
        taken         = 1'b0;
        while (!taken) begin
            @(negedge clk_i);
            taken = !dec_full_o;
            @(posedge clk_i);
        end
        e.fu = fu;
        e.op = op;
        e.rd = rd;
        e.id = next_id;
        e.a  = use_pc ? dec_pc_i : ref_rf[rs1];
        e.b  = use_imm ? dec_imm_i : ref_rf[rs2];
        if (rd != '0) begin
            ref_rf[rd] = unit_result(op, e.a, e.b);
        end
        exp_q.push_back(e);
        next_id++;
        #1;
        dec_valid_i = 1'b0;
    endtask

    // small register range keeps hazards frequent
    task automatic send_random();
        fu_t    fu;
        fu_op_t op;
        fu = fu_t'($urandom_range(3, 1));
        op = (fu == LSU) ? fu_op_t'($urandom_range(6, 5)) :
             (fu == MULT) ? MUL : fu_op_t'($urandom_range(4, 0));
        send(fu, op, reg_addr_t'($urandom_range(7, 0)), reg_addr_t'($urandom_range(7, 0)),
             reg_addr_t'($urandom_range(7, 0)), $urandom_range(3, 0) == 0,
             $urandom_range(3, 0) == 0);
    endtask

    // wait until every issue is seen and written back, then let commits finish
    task automatic drain();
        @(negedge clk_i);
        while (exp_q.size() != 0 || wb_q.size() != 0) begin
            @(negedge clk_i);
        end
        @(posedge clk_i);
        #1;
        idle(`SB_DEPTH + 4);
    endtask

    // ----------------------------------------
    // execution unit models
    // ----------------------------------------
    initial begin : ready_drive
        forever begin
            @(posedge clk_i);
            #1;
            alu_ready_i  = !hold_ready && (force_ready || ($urandom_range(3, 0) != 0));
            lsu_ready_i  = !hold_ready && (force_ready || ($urandom_range(3, 0) != 0));
            mult_ready_i = !hold_ready && (force_ready || ($urandom_range(3, 0) != 0));
        end
    end

    // outputs are registered, stable at the falling edge
    always @(negedge clk_i) begin : unit_monitor
        exp_t e;
        wb_t  w;
        fu_t  seen;
        if (rst_ni && (alu_valid_o || lsu_valid_o || mult_valid_o)) begin
            seen = alu_valid_o ? ALU : (lsu_valid_o ? LSU : MULT);
            if (exp_q.size() == 0) begin
                report_error("unit valid without a pending instruction");
            end else begin
                e = exp_q.pop_front();
                expect_equal("unit", seen, e.fu);
                expect_equal("operator", operator_o, e.op);
                expect_equal("trans_id", trans_id_o, e.id);
                expect_equal("operand_a", operand_a_o, e.a);
                expect_equal("operand_b", operand_b_o, e.b);
                // an older writer of the same rd has to write back first
                if (e.rd != '0) begin
                    foreach (wb_q[i]) begin
                        if (wb_q[i].rd == e.rd) begin
                            report_error($sformatf("x%0d issued over a pending write", e.rd));
                        end
                    end
                end
                w.fu   = seen;
                w.rd   = e.rd;
                w.id   = trans_id_o;
                w.data = unit_result(operator_o, operand_a_o, operand_b_o);
                w.due  = cycle + $urandom_range(4, 1);
                wb_q.push_back(w);
            end
        end
    end

    // one strobe per cycle, oldest first within each unit
    initial begin : writeback_drive
        int pick;
        bit blocked;
        forever begin
            @(posedge clk_i);
            #1;
            wb_valid_i = 1'b0;
            pick       = -1;
            foreach (wb_q[i]) begin
                blocked = 1'b0;
                for (int j = 0; j < i; j++) begin
                    if (wb_q[j].fu == wb_q[i].fu) begin
                        blocked = 1'b1;
                    end
                end
                if (pick < 0 && !blocked && wb_q[i].due <= cycle) begin
                    pick = i;
                end
            end
            if (pick >= 0) begin
                wb_valid_i    = 1'b1;
                wb_trans_id_i = wb_q[pick].id;
                wb_data_i     = wb_q[pick].data;
                wb_q.delete(pick);
            end
        end
    end

    initial begin : watchdog
        #((N_INSTR * 40 + 200) * CLK_NS);
        $display("timeout: the run did not finish within %0d cycles", N_INSTR * 40 + 200);
        $display("=== FAIL ===");
        $finish;
    end

    // ----------------------------------------
    // test sequence
    // ----------------------------------------
    initial begin : main
        void'($urandom(32'h5d9e));
        rst_ni        = 1'b0;
        flush_i       = 1'b0;
        dec_valid_i   = 1'b0;
        dec_fu_i      = NONE;
        dec_op_i      = ADD;
        dec_rd_i      = '0;
        dec_rs1_i     = '0;
        dec_rs2_i     = '0;
        dec_imm_i     = '0;
        dec_use_imm_i = 1'b0;
        dec_pc_i      = '0;
        dec_use_pc_i  = 1'b0;
        wb_valid_i    = 1'b0;
        wb_trans_id_i = '0;
        wb_data_i     = '0;
        alu_ready_i   = 1'b0;
        lsu_ready_i   = 1'b0;
        mult_ready_i  = 1'b0;
        hold_ready    = 1'b1;
        force_ready   = 1'b0;
        next_id       = '0;
        val_errs      = 0;
        foreach (ref_rf[r]) begin
            ref_rf[r] = '0;
        end
        idle(2);
        rst_ni = 1'b1;
        // idle with ready units, nothing may issue
        set_hold(1'b0);
        idle(3);

        // random program with hazards and back-pressure
        repeat (N_RAND) begin
            send_random();
            idle($urandom_range(1, 0));
        end
        drain();

        // fill every slot while the units stall
        set_hold(1'b1);
        repeat (`SB_DEPTH) send_random();
        repeat (3) begin
            @(negedge clk_i);
            if (!dec_full_o) begin
                report_error("dec_full_o low with every slot taken");
            end
            @(posedge clk_i);
            #1;
        end
        set_hold(1'b0);
        drain();

        // flush a full scoreboard on the edge where the oldest entry issues
        set_hold(1'b1);
        saved_rf = ref_rf;
        repeat (N_FLUSH) send_random();
        @(negedge clk_i);
        hold_ready  = 1'b0;
        force_ready = 1'b1;
        @(posedge clk_i);
        #1;
        flush_i = 1'b1;
        idle(1);
        flush_i = 1'b0;
        exp_q.delete();
        next_id = '0;
        ref_rf  = saved_rf;
        @(negedge clk_i);
        expect_equal("dec_full_o after flush", dec_full_o, 1'b0);
        force_ready = 1'b0;
        @(posedge clk_i);
        #1;
        idle(4);

        repeat (N_TAIL) begin
            send_random();
            idle($urandom_range(1, 0));
        end
        drain();

        asrt_errs = dut0.u_asserts.fail_cnt;
        $display("errors: %0d value mismatches, %0d assertion failures", val_errs, asrt_errs);
        if (val_errs == 0 && asrt_errs == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
